/* sb_tx_top.f */
+incdir+common
common/sb_pkg.sv
sb_tx/sb_ready_gen.sv
sb_tx/sb_tx_port.sv
rtl/sb_queue.sv
rtl/sb_tx_top.sv
tests/sb_tx_checker.sv
tests/sb_tx_tb.sv

/* Bender.yml */
package:
  name: sb_tx

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/sb_pkg.sv
      - sb_tx/sb_ready_gen.sv
      - sb_tx/sb_tx_port.sv
      - rtl/sb_queue.sv
      - rtl/sb_tx_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/sb_tx_checker.sv
      - tests/sb_tx_tb.sv

/* tests/sb_tx_tb.sv */
// switchboard egress testbench
// random packets in three phases, one per ready mode, with a bursty
// consumer and one pop stall per phase, then a drain and a report
`timescale 1ns/1ps

`include "sb_params.svh"

module sb_tx_tb;

    localparam int PKTS_PER_PHASE = 200;
    localparam int CYCLE_LIMIT    = 3 * PKTS_PER_PHASE * 12 + 200;
    localparam int DRIVE_DELAY    = 10;
    localparam int STALL_CYCLES   = 30;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   end_of_test;
    sb_pkg::sb_ready_mode_e ready_mode;
    sb_pkg::sb_packet_t     in_pkt;
    logic                   in_valid;
    logic                   in_ready;
    sb_pkg::sb_packet_t     out_pkt;
    logic                   out_valid;
    logic                   pop;

    // consumer state, pop_on makes the pops come in bursts
    logic pop_on = 1'b0;
    int   stall_left = 0;
    int   cycle_count = 0;
    int   timeouts = 0;
    int   total_errors;

    always #50 clk = ~clk;

    sb_tx_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .ready_mode (ready_mode),
        .in_pkt     (in_pkt),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .out_pkt    (out_pkt),
        .out_valid  (out_valid),
        .pop        (pop)
    );

    sb_tx_checker i_chk (
        .clk         (clk),
        .rst_n       (rst_n),
        .end_of_test (end_of_test),
        .ready_mode  (ready_mode),
        .in_pkt      (in_pkt),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .out_pkt     (out_pkt),
        .out_valid   (out_valid),
        .pop         (pop)
    );

    function automatic sb_pkg::sb_packet_t random_packet();
        sb_pkg::sb_packet_t pkt;
        for (int i = 0; i < `SB_DATA_W / 32; i++) begin
            pkt.data[i*32 +: 32] = $urandom;
        end
        pkt.dest = $urandom;
        pkt.last = ($urandom_range(99) < 25);
        return pkt;
    endfunction

    task automatic print_counts();
        $display("error counts: value %0d, rule %0d, timeout %0d",
                 i_chk.value_errors, i_chk.rule_errors, timeouts);
    endtask

    // on to off at 45% and off to on at 30% gives pops about 40% of the time
    task automatic step_consumer();
        if (stall_left > 0) begin
            stall_left--;
            pop_on = 1'b0;
        end else if (pop_on) begin
            pop_on = ($urandom_range(99) >= 45);
        end else begin
            pop_on = ($urandom_range(99) < 30);
        end
        // out_valid is already settled this far after the edge
        pop = pop_on && out_valid;
    endtask

    task automatic run_phase(input sb_pkg::sb_ready_mode_e mode);
        int   sent;
        logic stalled;
        logic xfer;
        sent = 0;
        stalled = 1'b0;
        ready_mode = mode;
        while (sent < PKTS_PER_PHASE) begin
            @(posedge clk);
            // the registered in_ready still shows its value from before the edge
            xfer = in_valid && in_ready;
            #DRIVE_DELAY;
            if (xfer) begin
                sent++;
            end
            // an offer that has not been taken is held unchanged
            if (!in_valid || xfer) begin
                if (sent < PKTS_PER_PHASE && $urandom_range(99) < 70) begin
                    in_pkt = random_packet();
                    in_valid = 1'b1;
                end else begin
                    in_valid = 1'b0;
                end
            end
            if (!stalled && sent >= PKTS_PER_PHASE / 2) begin
                stall_left = STALL_CYCLES;
                stalled = 1'b1;
            end
            step_consumer();
        end
    endtask

    // pop everything, a held packet always keeps out_valid high
    task automatic drain_queue();
        int idle;
        idle = 0;
        while (idle < 2) begin
            @(posedge clk);
            #DRIVE_DELAY;
            pop = out_valid;
            if (out_valid) begin
                idle = 0;
            end else begin
                idle++;
            end
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            timeouts = 1;
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            print_counts();
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h183e_166b));
        rst_n = 1'b0;
        end_of_test = 1'b0;
        ready_mode = sb_pkg::wait_valid;
        in_pkt = '0;
        in_valid = 1'b0;
        pop = 1'b0;
        repeat (8) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        run_phase(sb_pkg::wait_valid);
        run_phase(sb_pkg::always_ready);
        run_phase(sb_pkg::random_ready);
        drain_queue();
        pop = 1'b0;
        end_of_test = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        total_errors = i_chk.value_errors + i_chk.rule_errors;
        print_counts();
        if (total_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* tests/sb_tx_checker.sv */
// switchboard egress checker
// watches the DUT ports, keeps a model of the accepted packets in order,
// checks the ready rules of each mode and counts errors
`timescale 1ns/1ps

`include "sb_params.svh"

module sb_tx_checker (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   end_of_test,
    input sb_pkg::sb_ready_mode_e ready_mode,
    input sb_pkg::sb_packet_t     in_pkt,
    input logic                   in_valid,
    input logic                   in_ready,
    input sb_pkg::sb_packet_t     out_pkt,
    input logic                   out_valid,
    input logic                   pop
);

    localparam int DEPTH = `SB_QUEUE_DEPTH;

    int value_errors = 0;
    int rule_errors = 0;

    // packets accepted by the port and not yet popped, oldest first
    sb_pkg::sb_packet_t model [$];
    sb_pkg::sb_packet_t expected;

    // set once reset has been applied at an edge
    logic                   reset_seen = 1'b0;
    // low until the first edge after rst_n rises has been seen
    logic                   was_running = 1'b0;
    sb_pkg::sb_ready_mode_e last_mode = sb_pkg::wait_valid;
    // edges since the mode last changed, saturating
    int                     mode_age = 0;
    logic                   last_valid = 1'b0;
    logic                   last_xfer = 1'b0;
    logic                   xfer;
    // model fill after the previous edge and after the one before it
    int                     cur_size = 0;
    int                     prev_size = 0;
    logic                   seen_ready_hi = 1'b0;
    logic                   seen_ready_lo = 1'b0;

    task automatic rule_error(input string what);
        rule_errors++;
        $display("Fail at %0t: %s", $time, what);
    endtask

    // the popped packet must be the oldest one in the model, field by field
    task automatic compare_head();
        if (model.size() == 0) begin
            rule_error("packet popped although none was accepted");
        end else begin
            expected = model.pop_front();
            if (out_pkt.data !== expected.data) begin
                value_errors++;
                $display("Fail at %0t: data mismatch, got %h, expected %h",
                         $time, out_pkt.data, expected.data);
            end
            if (out_pkt.dest !== expected.dest) begin
                value_errors++;
                $display("Fail at %0t: dest mismatch, got %h, expected %h",
                         $time, out_pkt.dest, expected.dest);
            end
            if (out_pkt.last !== expected.last) begin
                value_errors++;
                $display("Fail at %0t: last mismatch, got %b, expected %b",
                         $time, out_pkt.last, expected.last);
            end
        end
    endtask

    // in_ready seen here was set at the previous edge, so it is judged
    // against the inputs and the model fill of the cycles before it
    task automatic check_ready_rules();
        // a full queue plus one held packet must close the port
        if (cur_size == DEPTH + 1 && in_ready) begin
            rule_error("in_ready high with the queue full and a packet held");
        end
        if (mode_age >= 2) begin
            case (ready_mode)
                sb_pkg::wait_valid: begin
                    if (in_ready && !last_valid) begin
                        rule_error("in_ready high in wait_valid mode without a valid before");
                    end
                    if (xfer && last_xfer) begin
                        rule_error("transfers on consecutive edges in wait_valid mode");
                    end
                end
                sb_pkg::always_ready: begin
                    if (!in_ready && cur_size < DEPTH && prev_size < DEPTH) begin
                        rule_error("in_ready low in always_ready mode with room in the queue");
                    end
                end
                sb_pkg::random_ready: begin
                    if (in_ready) begin
                        seen_ready_hi = 1'b1;
                    end else begin
                        seen_ready_lo = 1'b1;
                    end
                end
            endcase
        end
    endtask

    always @(posedge clk) begin
        // out of reset both outputs stay low until the port has seen an edge
        if (reset_seen && !was_running) begin
            if (in_ready !== 1'b0 || out_valid !== 1'b0) begin
                rule_error("in_ready or out_valid not low after reset");
            end
        end
        if (!rst_n || ready_mode != last_mode) begin
            mode_age = 0;
        end else if (mode_age < 8) begin
            mode_age++;
        end
        last_mode = ready_mode;
        if (rst_n && was_running) begin
            xfer = in_valid && in_ready;
            cur_size = model.size();
            // a held packet only exists next to a full queue, so the queue
            // shows a packet exactly when the model holds any
            if (out_valid !== (cur_size != 0)) begin
                rule_error("out_valid does not match the packets held in the queue");
            end
            check_ready_rules();
            // a packet accepted at this edge cannot leave at the same edge
            if (pop && out_valid) begin
                compare_head();
            end
            if (xfer) begin
                model.push_back(in_pkt);
            end
            if (model.size() > DEPTH + 1) begin
                rule_error("more packets accepted than the queue and the port can hold");
            end
            last_valid = in_valid;
            last_xfer = xfer;
            prev_size = cur_size;
        end
        if (!rst_n) begin
            reset_seen = 1'b1;
        end
        was_running = rst_n;
    end

    // the testbench raises end_of_test once the queue has been drained
    always @(posedge end_of_test) begin
        if (model.size() != 0) begin
            rule_error($sformatf("%0d accepted packets never came out", model.size()));
        end
        if (!(seen_ready_hi && seen_ready_lo)) begin
            rule_error("in_ready did not take both values in random_ready mode");
        end
    end

endmodule

/* rtl/sb_tx_top.sv */
// switchboard egress top level
// the egress port feeding its bounded queue, producer on one side,
// pop-strobe consumer on the other
`timescale 1ns/1ps

module sb_tx_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  sb_pkg::sb_ready_mode_e ready_mode,
    input  sb_pkg::sb_packet_t     in_pkt,
    input  logic                   in_valid,
    output logic                   in_ready,
    output sb_pkg::sb_packet_t     out_pkt,
    output logic                   out_valid,
    input  logic                   pop
);

    // push request and its packet from the port
    logic               push;
    sb_pkg::sb_packet_t push_pkt;
    // back-pressure from the queue, seen by the port in the same cycle
    logic               full;

    sb_tx_port i_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .ready_mode (ready_mode),
        .in_pkt     (in_pkt),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .push       (push),
        .push_pkt   (push_pkt),
        .full       (full)
    );

    sb_queue i_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_pkt  (push_pkt),
        .full      (full),
        .out_pkt   (out_pkt),
        .out_valid (out_valid),
        .pop       (pop)
    );

endmodule

/* rtl/sb_queue.sv */
// switchboard egress queue
// bounded circular buffer of packets, a push is refused when full,
// the head packet is shown with a not-empty level and drained by pop
`timescale 1ns/1ps

`include "sb_params.svh"

module sb_queue (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               push,
    input  sb_pkg::sb_packet_t push_pkt,
    output logic               full,
    output sb_pkg::sb_packet_t out_pkt,
    output logic               out_valid,
    input  logic               pop
);

    localparam int DEPTH = `SB_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    sb_pkg::sb_packet_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic do_push;
    logic do_pop;

    // full and empty come straight from the registered count,
    // so a pop in the same cycle does not free a slot for a push yet
    assign full      = (count == CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign out_pkt   = mem[rd_ptr];

    assign do_push = push && !full;
    // a pop against an empty queue is dropped here
    assign do_pop  = pop && out_valid;

    // pointers wrap explicitly so any depth works, not only powers of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            unique case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                // push and pop together leave the fill unchanged
                default: count <= count;
            endcase
        end
    end

    // storage only, the count decides which entries are valid
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_pkt;
        end
    end

    a_count_bound : assert property (
        @(posedge clk) disable iff (!rst_n)
        count <= CNT_W'(DEPTH)
    ) else $error("queue count above depth");

    // the consumer is expected to look at out_valid before popping
    a_no_pop_empty : assert property (
        @(posedge clk) disable iff (!rst_n)
        pop |-> out_valid
    ) else $error("pop while queue empty");

endmodule

/* sb_tx/sb_tx_port.sv */
// switchboard egress port
// accepts packets over valid/ready, pushes them into the egress queue
// and holds one packet for retry when the queue is full
`timescale 1ns/1ps

module sb_tx_port (
    input  logic                   clk,
    input  logic                   rst_n,
    input  sb_pkg::sb_ready_mode_e ready_mode,
    input  sb_pkg::sb_packet_t     in_pkt,
    input  logic                   in_valid,
    output logic                   in_ready,
    output logic                   push,
    output sb_pkg::sb_packet_t     push_pkt,
    input  logic                   full
);

    // a new packet is handed over in this cycle
    logic               xfer;
    // the push attempted in this cycle went into the queue
    logic               push_ok;
    // the push attempted in this cycle bounced off a full queue
    logic               push_fail;
    // a packet is waiting for room in the queue
    logic               pending;
    // copy of the packet that bounced
    sb_pkg::sb_packet_t pend_pkt;
    // answer of the ready policy for the next cycle
    logic               want_ready;

    assign xfer = in_valid && in_ready;

    // in_ready is never high while pending, so a new packet and a retry
    // cannot collide and one push port is enough
    assign push     = xfer || pending;
    assign push_pkt = xfer ? in_pkt : pend_pkt;

    // full reflects the count at the start of the cycle only
    assign push_ok   = push && !full;
    assign push_fail = push && full;

    sb_ready_gen i_ready_gen (
        .clk        (clk),
        .rst_n      (rst_n),
        .ready_mode (ready_mode),
        .valid      (in_valid),
        .sent       (push_ok),
        .want_ready (want_ready)
    );

    // pending is set by any failed push and cleared by a successful one
    // a retry that fails again just keeps it set
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else begin
            pending <= push_fail;
        end
    end

    // only a fresh packet that fails needs to be captured
    // a failing retry already lives in pend_pkt
    always_ff @(posedge clk) begin
        if (xfer && full) begin
            pend_pkt <= in_pkt;
        end
    end

    // ready is registered and decided once per cycle
    // a bounced packet closes the port until its retry gets through
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_ready <= 1'b0;
        end else if (push_fail) begin
            in_ready <= 1'b0;
        end else begin
            in_ready <= want_ready;
        end
    end

    // with a packet held there is no room for another one
    a_no_ready_while_pending : assert property (
        @(posedge clk) disable iff (!rst_n)
        pending |-> !in_ready
    ) else $error("in_ready high while a packet is pending");

    // a packet that keeps bouncing must be offered unchanged each retry
    a_retry_stable : assert property (
        @(posedge clk) disable iff (!rst_n)
        (pending && $past(pending)) |-> $stable(push_pkt)
    ) else $error("pending packet changed between retries");

    // a held packet is retried in every cycle until it lands
    // and the retry carries the held copy and never a fresh packet
    a_retry_every_cycle : assert property (
        @(posedge clk) disable iff (!rst_n)
        pending |-> (push && push_pkt == pend_pkt)
    ) else $error("pending packet not retried");

    // a failed push leaves the port holding that very packet
    a_fail_captures : assert property (
        @(posedge clk) disable iff (!rst_n)
        push_fail |=> (pending && push_pkt == $past(push_pkt))
    ) else $error("failed push not held for retry");

endmodule

/* sb_tx/sb_ready_gen.sv */
// egress ready policy
// picks the next ready value for the egress port from the selected
// mode, with a free-running 16-bit LFSR as the random source
`timescale 1ns/1ps

`include "sb_params.svh"

module sb_ready_gen (
    input  logic                   clk,
    input  logic                   rst_n,
    input  sb_pkg::sb_ready_mode_e ready_mode,
    input  logic                   valid,
    input  logic                   sent,
    output logic                   want_ready
);

    logic [15:0] lfsr;
    logic        lfsr_fb;

    // taps 16, 14, 13 and 11 give a maximal-length sequence
    // so the stream only repeats after 65535 cycles
    assign lfsr_fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    // the register shifts every cycle whatever the mode is,
    // so switching into random mode does not restart the sequence
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr <= `SB_LFSR_SEED;
        end else begin
            lfsr <= {lfsr[14:0], lfsr_fb};
        end
    end

    // the port only consults this when the last decision did not fail,
    // a failed push overrides whatever is chosen here
    always_comb begin
        unique case (ready_mode)
            // after a send wait for the next valid before opening again
            sb_pkg::wait_valid:   want_ready = valid && !sent;
            sb_pkg::always_ready: want_ready = 1'b1;
            sb_pkg::random_ready: want_ready = lfsr[0];
            // unused encoding keeps the port closed
            default:              want_ready = 1'b0;
        endcase
    end

endmodule

/* common/sb_pkg.sv */
// switchboard shared types
// packet layout as it travels from producer through the egress
// queue, and the ready policy selector of the egress port
package sb_pkg;

    `include "sb_params.svh"

    // one switchboard packet as a single packed word
    // data sits in the upper bits, last is bit 0
    typedef struct packed {
        // payload bits
        logic [`SB_DATA_W-1:0] data;
        // destination id, not interpreted by this port
        logic [`SB_DEST_W-1:0] dest;
        // marks the final packet of a message
        logic                  last;
    } sb_packet_t;

    // ready policy of the egress port
    // the encoding matches the numeric modes used by the switchboard
    // software side, so 0, 1 and 2 keep their meaning
    typedef enum logic [1:0] {
        // ready is raised only after valid has been seen
        wait_valid   = 2'd0,
        // ready is held high whenever nothing is stuck
        always_ready = 2'd1,
        // ready follows a pseudo random bit stream
        random_ready = 2'd2
    } sb_ready_mode_e;

endpackage

/* common/sb_params.svh */
// switchboard egress parameters
// widths of the packet fields, egress queue depth and the seed
// of the random ready policy
`ifndef SB_PARAMS_SVH
`define SB_PARAMS_SVH

// payload carried by one packet, one full word
`define SB_DATA_W 256

// destination field, carried along but not decoded by the port
`define SB_DEST_W 32

// number of packets the egress queue can hold
`define SB_QUEUE_DEPTH 4

// start value of the random-mode LFSR, must not be zero
// or the register would lock up
`define SB_LFSR_SEED 16'hace1

`endif
